// ==== lvda.f ====
+incdir+.
lvda_bus_pkg.sv
lvda_time_pkg.sv
lvda_timing.sv
lvda_ctrl.sv
lvda_discrete_sampler.sv
lvda_countdown.sv
lvda_telemetry_ser.sv
lvda.sv
lvda_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the LVDA testbench with Verilator, then judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module lvda_tb -f lvda.f -o lvda_sim \
    > build.log 2>&1 \
    && ./obj_dir/lvda_sim > sim.log 2>&1 \
    || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Everything OK" sim.log || { echo "FAIL: no result in sim.log"; exit 1; }
echo "PASS"

// ==== lvda_tb.sv ====
`default_nettype none

`include "lvda_config.svh"

module lvda_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TICK_CLKS  = 4 * `LVDA_TICK_DIV;  // Clocks per bit tick.
    localparam int XFER_LIMIT = 40 * TICK_CLKS;

    typedef logic [`LVDA_DISC_W-1:0] disc_t;
    typedef enum logic [1:0] {OP_WR, OP_RD, OP_SER, OP_IRQ} op_e;

    typedef struct packed {
        op_e                 op;
        lvda_bus_pkg::addr_t addr;
        lvda_bus_pkg::word_t data;   // Write data, or tick count for OP_IRQ.
        disc_t               disc;
        lvda_bus_pkg::word_t exp;
        logic                err;
        logic                stall;
        int                  ticks;  // Idle ticks before the step.
    } step_t;

    logic                sim_clk = 1'b0;
    logic                arst_n;
    logic                psel;
    logic                penable;
    logic                pwrite;
    lvda_bus_pkg::addr_t paddr;
    lvda_bus_pkg::word_t pwdata;
    lvda_bus_pkg::word_t prdata;
    logic                pready;
    logic                pslverr;
    disc_t               disc;
    logic                irq;
    logic                data;
    logic                data_clk;

    step_t  steps[$];
    logic   rx_bits[$];
    disc_t  disc_val;
    integer seed;
    int     checks = 0;
    int     errors = 0;
    int     timeouts = 0;
    int     stall_cycles;
    int     cur_step;

    lvda u_lvda (.*);

    always #50 sim_clk = ~sim_clk;

    // Serial receiver. One bit per data_clk pulse.
    always @(negedge sim_clk) begin
        if (arst_n && data_clk)
            rx_bits.push_back(data);
    end

    task automatic verify(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("Error at %0d ns: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout on step %0d: %s", cur_step, what);
        timeouts++;
        errors++;
    endtask

    function automatic void add_step(op_e op, lvda_bus_pkg::addr_t addr,
                                     lvda_bus_pkg::word_t wd, lvda_bus_pkg::word_t exp,
                                     logic err, logic stall, int ticks);
        steps.push_back('{op, addr, wd, disc_val, exp, err, stall, ticks});
    endfunction

    task automatic apb_transfer(input logic wr, input lvda_bus_pkg::addr_t addr,
                                input lvda_bus_pkg::word_t wd,
                                output lvda_bus_pkg::word_t rd, output logic err);
        int waited;
        @(posedge sim_clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wd;
        @(posedge sim_clk);
        penable <= 1'b1;
        waited = 0;
        @(negedge sim_clk);
        while (!pready && waited < XFER_LIMIT) begin
            @(negedge sim_clk);
            waited++;
        end
        if (!pready)
            report_timeout("pready never rose");
        rd = prdata;
        err = pslverr;
        stall_cycles = waited;
        @(posedge sim_clk);  // Completing edge.
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic receive_word(output lvda_bus_pkg::word_t word);
        int waited;
        waited = 0;
        word = '0;
        while (rx_bits.size() < `LVDA_DATA_W && waited < (`LVDA_DATA_W + 4) * TICK_CLKS) begin
            @(negedge sim_clk);
            waited++;
        end
        if (rx_bits.size() < `LVDA_DATA_W) begin
            report_timeout("too few data_clk pulses");
            rx_bits.delete();
        end else begin
            repeat (`LVDA_DATA_W)
                word = {word[`LVDA_DATA_W-2:0], rx_bits.pop_front()};  // MSB first.
        end
    endtask

    task automatic wait_irq_high(input int ticks);
        int waited;
        waited = 0;
        @(negedge sim_clk);
        while (!irq && waited < ticks * TICK_CLKS) begin
            @(negedge sim_clk);
            waited++;
        end
        if (!irq)
            report_timeout("irq did not rise");
    endtask

    task automatic hold_irq_low(input int ticks);
        logic seen;
        seen = 1'b0;
        repeat (ticks * TICK_CLKS) begin
            @(negedge sim_clk);
            seen |= irq;
        end
        verify(!seen, $sformatf("step %0d irq rose within %0d ticks", cur_step, ticks));
    endtask

    function automatic void build_table();
        lvda_bus_pkg::word_t n;
        lvda_bus_pkg::word_t w1;
        lvda_bus_pkg::word_t w2;
        lvda_bus_pkg::word_t w3;
        disc_val = '0;
        add_step(OP_RD, lvda_bus_pkg::REG_COUNT, '0, '0, 1'b0, 1'b0, 0);
        add_step(OP_RD, lvda_bus_pkg::REG_STATUS, '0, '0, 1'b0, 1'b0, 0);
        disc_val = disc_t'($random(seed));
        add_step(OP_RD, lvda_bus_pkg::REG_DISC, '0, disc_val, 1'b0, 1'b0, 4);
        disc_val = disc_t'($random(seed));
        add_step(OP_RD, lvda_bus_pkg::REG_DISC, '0, disc_val, 1'b0, 1'b0, 4);
        n = lvda_bus_pkg::word_t'(3 + {$random(seed)} % 3);
        add_step(OP_WR, lvda_bus_pkg::REG_COUNT, n, '0, 1'b0, 1'b0, 0);
        add_step(OP_IRQ, '0, n + 16'd2, 16'd1, 1'b0, 1'b0, 0);
        add_step(OP_RD, lvda_bus_pkg::REG_COUNT, '0, '0, 1'b0, 1'b0, 0);
        add_step(OP_RD, lvda_bus_pkg::REG_STATUS, '0, 16'd1, 1'b0, 1'b0, 0);
        add_step(OP_WR, lvda_bus_pkg::REG_STATUS, 16'd1, '0, 1'b0, 1'b0, 0);
        add_step(OP_IRQ, '0, 16'd1, '0, 1'b0, 1'b0, 0);
        add_step(OP_WR, lvda_bus_pkg::REG_COUNT, '0, '0, 1'b0, 1'b0, 0);
        add_step(OP_IRQ, '0, 16'd10, '0, 1'b0, 1'b0, 0);  // Zero load stays quiet.
        w1 = lvda_bus_pkg::word_t'($random(seed));
        w2 = lvda_bus_pkg::word_t'($random(seed));
        w3 = lvda_bus_pkg::word_t'($random(seed));
        add_step(OP_WR, lvda_bus_pkg::REG_TLM, w1, '0, 1'b0, 1'b0, 0);
        add_step(OP_RD, lvda_bus_pkg::REG_STATUS, '0, 16'd2, 1'b0, 1'b0, 0);  // Busy shows.
        add_step(OP_SER, '0, '0, w1, 1'b0, 1'b0, 0);
        add_step(OP_RD, lvda_bus_pkg::REG_STATUS, '0, '0, 1'b0, 1'b0, 2);
        add_step(OP_WR, lvda_bus_pkg::REG_TLM, w2, '0, 1'b0, 1'b0, 0);
        add_step(OP_WR, lvda_bus_pkg::REG_TLM, w3, '0, 1'b0, 1'b1, 0);
        add_step(OP_SER, '0, '0, w2, 1'b0, 1'b0, 0);
        add_step(OP_SER, '0, '0, w3, 1'b0, 1'b0, 0);
        add_step(OP_WR, lvda_bus_pkg::REG_DISC, 16'h1234, '0, 1'b1, 1'b0, 0);
        add_step(OP_RD, lvda_bus_pkg::REG_TLM, '0, '0, 1'b1, 1'b0, 0);
        add_step(OP_RD, lvda_bus_pkg::addr_t'(2), '0, '0, 1'b1, 1'b0, 0);
        add_step(OP_WR, lvda_bus_pkg::addr_t'(15), 16'h00ff, '0, 1'b1, 1'b0, 0);
        add_step(OP_RD, lvda_bus_pkg::REG_COUNT, '0, '0, 1'b0, 1'b0, 0);
    endfunction

    initial begin : main
        step_t               st;
        lvda_bus_pkg::word_t rd;
        logic                err;
        seed = 32'he006_02b9;
        arst_n  <= 1'b0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        disc    <= '0;
        build_table();
        repeat (3) @(posedge sim_clk);
        arst_n <= 1'b1;
        @(negedge sim_clk);
        verify(!irq && !data && !data_clk && !pslverr && !pready,
               "outputs not at their reset values");
        for (int i = 0; i < steps.size(); i++) begin
            st = steps[i];
            cur_step = i;
            @(posedge sim_clk);
            disc <= st.disc;
            repeat (st.ticks * TICK_CLKS) @(posedge sim_clk);
            case (st.op)
                OP_WR: begin
                    apb_transfer(1'b1, st.addr, st.data, rd, err);
                    verify(err == st.err,
                           $sformatf("step %0d write pslverr %0b, expected %0b", i, err, st.err));
                    if (st.stall)
                        verify(stall_cycles > 1,
                               $sformatf("step %0d write was not held off", i));
                end
                OP_RD: begin
                    apb_transfer(1'b0, st.addr, '0, rd, err);
                    verify(err == st.err,
                           $sformatf("step %0d read pslverr %0b, expected %0b", i, err, st.err));
                    if (!st.err)
                        verify(rd == st.exp,
                               $sformatf("step %0d read 0x%h, expected 0x%h", i, rd, st.exp));
                end
                OP_SER: begin
                    receive_word(rd);
                    verify(rd == st.exp,
                           $sformatf("step %0d serial word 0x%h, expected 0x%h", i, rd, st.exp));
                end
                default: begin
                    if (st.exp[0])
                        wait_irq_high(int'(st.data));
                    else
                        hold_irq_low(int'(st.data));
                end
            endcase
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== lvda.sv ====
`default_nettype none

`include "lvda_config.svh"

module lvda (
    input  logic                     sim_clk,
    input  logic                     arst_n,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  lvda_bus_pkg::addr_t      paddr,
    input  lvda_bus_pkg::word_t      pwdata,
    output lvda_bus_pkg::word_t      prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic [`LVDA_DISC_W-1:0]  disc,
    output logic                     irq,
    output logic                     data,
    output logic                     data_clk
);

    lvda_time_pkg::phase_e phase;
    logic                  tick;
    logic                  cnt_load;
    logic                  int_clr;
    logic                  tlm_load;
    lvda_bus_pkg::word_t   wdata;
    lvda_bus_pkg::word_t   disc_word;
    lvda_bus_pkg::word_t   count;
    logic                  irq_pend;
    logic                  busy;

    lvda_timing u_timing (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .phase   (phase),
        .tick    (tick)
    );

    lvda_ctrl u_ctrl (
        .sim_clk   (sim_clk),
        .arst_n    (arst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cnt_load  (cnt_load),
        .int_clr   (int_clr),
        .tlm_load  (tlm_load),
        .wdata     (wdata),
        .disc_word (disc_word),
        .count     (count),
        .irq_pend  (irq_pend),
        .busy      (busy)
    );

    lvda_discrete_sampler u_sampler (
        .sim_clk   (sim_clk),
        .arst_n    (arst_n),
        .disc      (disc),
        .phase     (phase),
        .tick      (tick),
        .disc_word (disc_word)
    );

    lvda_countdown u_countdown (
        .sim_clk  (sim_clk),
        .arst_n   (arst_n),
        .tick     (tick),
        .cnt_load (cnt_load),
        .int_clr  (int_clr),
        .wdata    (wdata),
        .count    (count),
        .irq_pend (irq_pend)
    );

    lvda_telemetry_ser u_ser (
        .sim_clk  (sim_clk),
        .arst_n   (arst_n),
        .tick     (tick),
        .tlm_load (tlm_load),
        .wdata    (wdata),
        .data     (data),
        .data_clk (data_clk),
        .busy     (busy)
    );

    assign irq = irq_pend;

endmodule

`default_nettype wire

// ==== lvda_telemetry_ser.sv ====
`default_nettype none

`include "lvda_config.svh"

module lvda_telemetry_ser (
    input  logic                 sim_clk,
    input  logic                 arst_n,
    input  logic                 tick,
    input  logic                 tlm_load,
    input  lvda_bus_pkg::word_t  wdata,
    output logic                 data,
    output logic                 data_clk,
    output logic                 busy
);

    localparam int CNT_W = $clog2(`LVDA_DATA_W + 1);
    localparam logic [CNT_W-1:0] ALL_SENT = CNT_W'(`LVDA_DATA_W);

    lvda_bus_pkg::word_t shift_q;
    logic [CNT_W-1:0]    bit_cnt;
    logic                shift_en;

    assign shift_en = busy && tick && (bit_cnt != ALL_SENT);

    always_ff @(posedge sim_clk) begin
        if (tlm_load)
            shift_q <= wdata;
        else if (shift_en)
            shift_q <= shift_q << 1;
    end

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            bit_cnt  <= '0;
            data     <= 1'b0;
            data_clk <= 1'b0;
        end else begin
            data_clk <= 1'b0;
            if (tlm_load) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (shift_en) begin
                data     <= shift_q[`LVDA_DATA_W-1];  // MSB first.
                data_clk <= 1'b1;
                bit_cnt  <= bit_cnt + 1'b1;
            end else if (busy && tick) begin
                busy <= 1'b0;  // Tick after the last bit.
            end
        end
    end

endmodule

`default_nettype wire

// ==== lvda_countdown.sv ====
`default_nettype none

module lvda_countdown (
    input  logic                 sim_clk,
    input  logic                 arst_n,
    input  logic                 tick,
    input  logic                 cnt_load,
    input  logic                 int_clr,
    input  lvda_bus_pkg::word_t  wdata,
    output lvda_bus_pkg::word_t  count,
    output logic                 irq_pend
);

    logic expire;

    // Step from 1 to 0, unless a load takes the cycle.
    assign expire = tick && !cnt_load && (count == lvda_bus_pkg::word_t'(1));

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (cnt_load) begin
            count <= wdata;
        end else if (tick && count != '0) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            irq_pend <= 1'b0;
        end else if (expire) begin
            irq_pend <= 1'b1;  // Wins over a clear.
        end else if (int_clr) begin
            irq_pend <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== lvda_discrete_sampler.sv ====
`default_nettype none

`include "lvda_config.svh"

module lvda_discrete_sampler (
    input  logic                     sim_clk,
    input  logic                     arst_n,
    input  logic [`LVDA_DISC_W-1:0]  disc,
    input  lvda_time_pkg::phase_e    phase,
    input  logic                     tick,
    output lvda_bus_pkg::word_t      disc_word
);

    logic [`LVDA_DISC_W-1:0] sync_a;
    logic [`LVDA_DISC_W-1:0] sync_b;
    logic                    armed;  // Tick seen, waiting for phase w.

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_a    <= '0;
            sync_b    <= '0;
            armed     <= 1'b0;
            disc_word <= '0;
        end else begin
            sync_a <= disc;
            sync_b <= sync_a;
            if (armed && phase == lvda_time_pkg::PH_W) begin
                disc_word <= lvda_bus_pkg::word_t'(sync_b);
                armed     <= 1'b0;
            end else if (tick) begin
                armed <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== lvda_ctrl.sv ====
`default_nettype none

module lvda_ctrl (
    input  logic                 sim_clk,
    input  logic                 arst_n,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  lvda_bus_pkg::addr_t  paddr,
    input  lvda_bus_pkg::word_t  pwdata,
    output lvda_bus_pkg::word_t  prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic                 cnt_load,
    output logic                 int_clr,
    output logic                 tlm_load,
    output lvda_bus_pkg::word_t  wdata,
    input  lvda_bus_pkg::word_t  disc_word,
    input  lvda_bus_pkg::word_t  count,
    input  logic                 irq_pend,
    input  logic                 busy
);

    typedef enum logic [1:0] {IDLE, ACCESS, WAIT_SER} state_e;

    state_e              state;
    lvda_bus_pkg::addr_t addr_q;
    logic                write_q;
    logic                setup;
    logic                xfer_done;
    logic                bad;
    logic                wr_ok;

    assign setup = psel && !penable;

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (setup) begin
                        // Telemetry write waits for the serializer.
                        if (pwrite && paddr == lvda_bus_pkg::REG_TLM && busy)
                            state <= WAIT_SER;
                        else
                            state <= ACCESS;
                    end
                end
                WAIT_SER: if (!busy) state <= ACCESS;
                default:  state <= IDLE;
            endcase
        end
    end

    // Address and direction held from the setup cycle.
    always_ff @(posedge sim_clk) begin
        if (state == IDLE && setup) begin
            addr_q  <= paddr;
            write_q <= pwrite;
        end
    end

    always_comb begin
        case (addr_q)
            lvda_bus_pkg::REG_DISC:   bad = write_q;
            lvda_bus_pkg::REG_COUNT:  bad = 1'b0;
            lvda_bus_pkg::REG_STATUS: bad = 1'b0;
            lvda_bus_pkg::REG_TLM:    bad = !write_q;
            default:                  bad = 1'b1; // Unmapped.
        endcase
    end

    assign xfer_done = (state == ACCESS) && psel && penable;
    assign pready    = xfer_done;
    assign pslverr   = xfer_done && bad;
    assign wr_ok     = xfer_done && write_q && !bad;

    always_comb begin
        prdata = '0;
        if (xfer_done && !write_q) begin
            case (addr_q)
                lvda_bus_pkg::REG_DISC:   prdata = disc_word;
                lvda_bus_pkg::REG_COUNT:  prdata = count;
                lvda_bus_pkg::REG_STATUS: prdata = lvda_bus_pkg::word_t'({busy, irq_pend});
                default:                  prdata = '0;
            endcase
        end
    end

    // One-cycle strobes in the completing cycle.
    assign cnt_load = wr_ok && (addr_q == lvda_bus_pkg::REG_COUNT);
    assign int_clr  = wr_ok && (addr_q == lvda_bus_pkg::REG_STATUS) && pwdata[0];
    assign tlm_load = wr_ok && (addr_q == lvda_bus_pkg::REG_TLM);
    assign wdata    = pwdata;

endmodule

`default_nettype wire

// ==== lvda_timing.sv ====
`default_nettype none

`include "lvda_config.svh"

module lvda_timing (
    input  logic                  sim_clk,
    input  logic                  arst_n,
    output lvda_time_pkg::phase_e phase,
    output logic                  tick
);

    localparam lvda_time_pkg::tick_cnt_t LAST_ROUND =
        lvda_time_pkg::tick_cnt_t'(`LVDA_TICK_DIV - 1);

    lvda_time_pkg::tick_cnt_t rounds;

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= lvda_time_pkg::PH_W;
        end else begin
            case (phase)
                lvda_time_pkg::PH_W: phase <= lvda_time_pkg::PH_X;
                lvda_time_pkg::PH_X: phase <= lvda_time_pkg::PH_Y;
                lvda_time_pkg::PH_Y: phase <= lvda_time_pkg::PH_Z;
                default:             phase <= lvda_time_pkg::PH_W;
            endcase
        end
    end

    // Round counter steps at the end of each z phase.
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            rounds <= '0;
        end else if (phase == lvda_time_pkg::PH_Z) begin
            rounds <= (rounds == LAST_ROUND) ? '0 : rounds + 1'b1;
        end
    end

    assign tick = (phase == lvda_time_pkg::PH_Z) && (rounds == LAST_ROUND);

endmodule

`default_nettype wire

// ==== lvda_time_pkg.sv ====
`default_nettype none

`include "lvda_config.svh"

package lvda_time_pkg;

    // Four clock phases of one round.
    typedef enum logic [1:0] {PH_W, PH_X, PH_Y, PH_Z} phase_e;

    typedef logic [$clog2(`LVDA_TICK_DIV + 1)-1:0] tick_cnt_t;

endpackage

`default_nettype wire

// ==== lvda_bus_pkg.sv ====
`default_nettype none

`include "lvda_config.svh"

package lvda_bus_pkg;

    typedef logic [`LVDA_ADDR_W-1:0] addr_t;
    typedef logic [`LVDA_DATA_W-1:0] word_t;

    // Register map.
    localparam addr_t REG_DISC   = addr_t'(0);  // Read only.
    localparam addr_t REG_COUNT  = addr_t'(4);
    localparam addr_t REG_STATUS = addr_t'(8);  // Bit 0 irq, bit 1 busy.
    localparam addr_t REG_TLM    = addr_t'(12); // Write only.

endpackage

`default_nettype wire

// ==== lvda_config.svh ====
`ifndef LVDA_CONFIG_SVH
`define LVDA_CONFIG_SVH

// Processor bus widths.
`define LVDA_ADDR_W 4
`define LVDA_DATA_W 16

// Discrete input count.
`define LVDA_DISC_W 16

// Full w-z rounds per bit tick.
`define LVDA_TICK_DIV 2

`endif
